// File: design/neoSysPkg.sv
/*
 * NeoGeo system-side definitions
 * Board variants, 68000 bus widths and the backup RAM window
 * shared by the CPU glue and the top level
 */
package neoSysPkg;

	// ====================================================================
	// Board variant
	// ====================================================================

	// Bit 1 set marks the CD based systems
	typedef enum logic [1:0] {
		SYS_AES = 2'b00,
		SYS_MVS = 2'b01,
		SYS_CD  = 2'b10,
		SYS_CDZ = 2'b11
	} systemType_e;

	// ====================================================================
	// 68000 bus
	// ====================================================================

	// Word address, bits 23 to 1
	localparam int M68K_ADDR_W = 23;
	// Data bus, also the palette word width
	localparam int DATA_W = 16;
	// Port zone bank register
	localparam int BANK_W = 4;
	// P2 ROM byte address
	localparam int PROM_ADDR_W = 24;
	// Interrupt priority lines IPL2..IPL0
	localparam int IPL_W = 3;

	// Backup RAM window on address bits 15 to 1
	// Lower bound included, upper bound excluded
	localparam logic [14:0] BACKUP_LO_WORD = 15'h0190;
	localparam logic [14:0] BACKUP_HI_WORD = 15'h4190;

endpackage

// File: design/neoVideoPkg.sv
/*
 * NeoGeo video-side definitions
 * Palette addressing, colour channel widths and pixel timing
 */
package neoVideoPkg;

	// ====================================================================
	// Palette memory
	// ====================================================================

	// Entry index inside one bank
	localparam int PAL_INDEX_W = 12;
	// Bank bit on top of the index
	localparam int PAL_ADDR_W = PAL_INDEX_W + 1;

	// ====================================================================
	// Colour output
	// ====================================================================

	// Final RGB channel width
	localparam int CHANNEL_W = 8;
	// Intermediate level, nibble plus extra bit plus repeated top bit
	localparam int LEVEL_W = 6;

	// ====================================================================
	// Pixel timing
	// ====================================================================

	// Master clock cycles per pixel, 48 MHz down to 6 MHz
	localparam int PIXEL_DIV = 8;
	// Phase counter width
	localparam int PHASE_W = $clog2(PIXEL_DIV);

endpackage

// File: design/clockEnables.sv
/*
 * Clock enable generator
 * Runs a phase counter off the 48 MHz master clock and produces
 * registered 24 MHz phase enables and the 6 MHz pixel enable
 */
module clockEnables import neoVideoPkg::*; (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic cen24P,
	output logic cen24N,
	output logic pixelEn
);

	// Current and next phase within one pixel period
	logic [PHASE_W-1:0] phase;
	logic [PHASE_W-1:0] phaseNext;

	// Wrap after the last phase of the pixel
	assign phaseNext = (phase == PHASE_W'(PIXEL_DIV - 1)) ? '0 : phase + 1'b1;

	// Enables are computed from the next phase
	// So each enable lines up with the phase value of its own cycle
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			phase   <= '0;
			cen24P  <= 1'b0;
			cen24N  <= 1'b0;
			pixelEn <= 1'b0;
		end else begin
			phase   <= phaseNext;
			// Odd phases
			cen24P  <= phaseNext[0];
			// Even phases
			cen24N  <= ~phaseNext[0];
			// One strobe per pixel on the last phase
			pixelEn <= (phaseNext == PHASE_W'(PIXEL_DIV - 1));
		end
	end

endmodule

// File: design/cpuBusGlue.sv
/*
 * 68000 side glue logic
 * Port zone banking and P2 address, interrupt re-encoding with the
 * CD interrupt, acknowledge stretching for slow memory and the
 * backup RAM change flag
 */
module cpuBusGlue import neoSysPkg::*; (
	input  logic                   CLK_48M,
	input  logic                   nRESET,
	input  systemType_e            systemType,
	input  logic [M68K_ADDR_W:1]   m68kAddr,
	input  logic [DATA_W-1:0]      m68kData,
	input  logic                   nPortWe,
	input  logic                   nBackupWeL,
	input  logic                   nBackupWeU,
	input  logic                   sramUnlock,
	input  logic                   romSel,
	input  logic                   ramSel,
	input  logic                   promReady,
	input  logic                   ramReady,
	input  logic                   nDtackIn,
	input  logic                   ipl0In,
	input  logic                   ipl1In,
	input  logic                   cdIrq,
	output logic [PROM_ADDR_W-1:0] p2RomAddr,
	output logic [IPL_W-1:0]       iplOut,
	output logic                   nDtackOut,
	output logic                   backupChange
);

	// CD and CDZ share the CD behaviour
	logic isCd;
	assign isCd = (systemType == SYS_CD) || (systemType == SYS_CDZ);

	// ====================================================================
	// Port zone bank switching
	// ====================================================================

	logic [BANK_W-1:0] portBank;
	logic [BANK_W-1:0] portDataHold;
	logic              nPortWeDly;
	logic              portWeRise;

	// Data is only valid while the strobe is low
	always_ff @(posedge CLK_48M) begin
		if (!nPortWe) begin
			portDataHold <= m68kData[BANK_W-1:0];
		end
	end

	// End of the write strobe
	assign portWeRise = nPortWe & ~nPortWeDly;

	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			nPortWeDly <= 1'b1;
			portBank   <= '0;
		end else begin
			nPortWeDly <= nPortWe;
			// Bank stays put on CD systems
			if (portWeRise && !isCd) begin
				portBank <= portDataHold;
			end
		end
	end

	// 1MB window selected by the bank, byte address
	assign p2RomAddr = {portBank, m68kAddr[19:1], 1'b0};

	// ====================================================================
	// Interrupt re-encoding
	// ====================================================================

	// Active low priority lines
	// CD systems swap IPL0 and IPL1 and put the CD interrupt on IPL2
	// An active CD interrupt forces level 4 by masking the lower lines
	assign iplOut[0] = isCd ? (cdIrq | ipl1In) : ipl0In;
	assign iplOut[1] = isCd ? (cdIrq | ipl0In) : ipl1In;
	assign iplOut[2] = isCd ? ~cdIrq : 1'b1;

	// ====================================================================
	// Acknowledge stretching
	// ====================================================================

	// Hold off DTACK until the slow memory has its data
	always_comb begin
		if (romSel) begin
			nDtackOut = ~promReady | nDtackIn;
		end else if (ramSel) begin
			nDtackOut = ~ramReady | nDtackIn;
		end else begin
			nDtackOut = nDtackIn;
		end
	end

	// ====================================================================
	// Backup RAM change flag
	// ====================================================================

	logic backupWr;
	logic backupWrDly;
	logic inBackupWindow;
	logic backupQualify;

	// Either byte lane counts
	assign backupWr = ~nBackupWeL | ~nBackupWeU;

	assign inBackupWindow = (m68kAddr[15:1] >= BACKUP_LO_WORD) &&
		(m68kAddr[15:1] < BACKUP_HI_WORD);

	// Backup RAM exists on MVS only, and needs the unlock bit
	assign backupQualify = (systemType == SYS_MVS) && sramUnlock && inBackupWindow;

	// One pulse per strobe, on its first cycle
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			backupWrDly  <= 1'b0;
			backupChange <= 1'b0;
		end else begin
			backupWrDly  <= backupWr;
			backupChange <= backupWr & ~backupWrDly & backupQualify;
		end
	end

endmodule

// File: design/paletteRam.sv
/*
 * Banked palette RAM
 * 8192 words split in two banks, CPU write port and
 * registered video read port
 */
module paletteRam import neoSysPkg::*, neoVideoPkg::*; (
	input  logic                   CLK_48M,
	input  logic                   palWe,
	input  logic                   palBank,
	input  logic [PAL_INDEX_W-1:0] palWrIndex,
	input  logic [DATA_W-1:0]      palData,
	input  logic [PAL_INDEX_W-1:0] rdIndex,
	output logic [DATA_W-1:0]      rdData
);

	// Both banks in one array
	logic [DATA_W-1:0] palMem [2**PAL_ADDR_W];

	// Bank bit on top of the index, same bank for both ports
	logic [PAL_ADDR_W-1:0] wrAddr;
	logic [PAL_ADDR_W-1:0] rdAddr;

	assign wrAddr = {palBank, palWrIndex};
	assign rdAddr = {palBank, rdIndex};

	always_ff @(posedge CLK_48M) begin
		if (palWe) begin
			palMem[wrAddr] <= palData;
		end
		// Read data one cycle after the address
		rdData <= palMem[rdAddr];
	end

endmodule

// File: design/colorDecode.sv
/*
 * Palette colour decoder
 * Turns a 16-bit palette word into 8-bit RGB with the dark bit
 * and the shadow halving, loaded once per pixel
 */
module colorDecode import neoSysPkg::*, neoVideoPkg::*; (
	input  logic                 CLK_48M,
	input  logic                 nRESET,
	input  logic                 pixelEn,
	input  logic                 shadow,
	input  logic [DATA_W-1:0]    colorWord,
	output logic [CHANNEL_W-1:0] red,
	output logic [CHANNEL_W-1:0] green,
	output logic [CHANNEL_W-1:0] blue
);

	// Nibble, extra bit and repeated top bit give a 6-bit level
	// The dark bit takes one step off, clamped at zero
	// Low bits are refilled from the level's upper bits
	function automatic logic [CHANNEL_W-1:0] expandChannel(
		input logic [3:0] nibble,
		input logic       extra,
		input logic       dark
	);
		logic [LEVEL_W:0] level;
		level = {1'b0, nibble, extra, nibble[3]} - {{LEVEL_W{1'b0}}, dark};
		if (level[LEVEL_W]) begin
			expandChannel = '0;
		end else begin
			expandChannel = {level[LEVEL_W-1:0], level[4:3]};
		end
	endfunction

	logic [CHANNEL_W-1:0] redLin;
	logic [CHANNEL_W-1:0] greenLin;
	logic [CHANNEL_W-1:0] blueLin;

	// Bit 15 is the shared dark bit
	assign redLin   = expandChannel(colorWord[11:8], colorWord[14], colorWord[15]);
	assign greenLin = expandChannel(colorWord[7:4], colorWord[13], colorWord[15]);
	assign blueLin  = expandChannel(colorWord[3:0], colorWord[12], colorWord[15]);

	// Shadow halves every channel
	always_ff @(posedge CLK_48M or negedge nRESET) begin
		if (!nRESET) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else if (pixelEn) begin
			red   <= shadow ? (redLin >> 1) : redLin;
			green <= shadow ? (greenLin >> 1) : greenLin;
			blue  <= shadow ? (blueLin >> 1) : blueLin;
		end
	end

endmodule

// File: design/neoSystemGlue.sv
/*
 * NeoGeo system glue top level
 * Clock enables, 68000 bus glue, palette RAM and colour output path
 */
module neoSystemGlue import neoSysPkg::*, neoVideoPkg::*; (
	input  logic                   CLK_48M,
	input  logic                   nRESET,
	// 68000 side
	input  systemType_e            systemType,
	input  logic [M68K_ADDR_W:1]   m68kAddr,
	input  logic [DATA_W-1:0]      m68kData,
	input  logic                   nPortWe,
	input  logic                   nBackupWeL,
	input  logic                   nBackupWeU,
	input  logic                   sramUnlock,
	input  logic                   romSel,
	input  logic                   ramSel,
	input  logic                   promReady,
	input  logic                   ramReady,
	input  logic                   nDtackIn,
	input  logic                   ipl0In,
	input  logic                   ipl1In,
	input  logic                   cdIrq,
	// Palette write port
	input  logic                   palWe,
	input  logic                   palBank,
	input  logic [PAL_INDEX_W-1:0] palWrIndex,
	input  logic [DATA_W-1:0]      palData,
	// Video side
	input  logic [PAL_INDEX_W-1:0] pixelIndex,
	input  logic                   shadow,
	output logic [CHANNEL_W-1:0]   red,
	output logic [CHANNEL_W-1:0]   green,
	output logic [CHANNEL_W-1:0]   blue,
	output logic                   pixelEn,
	output logic                   cen24P,
	output logic                   cen24N,
	// Bus glue outputs
	output logic [PROM_ADDR_W-1:0] p2RomAddr,
	output logic [IPL_W-1:0]       iplOut,
	output logic                   nDtackOut,
	output logic                   backupChange
);

	// Palette word on its way to the decoder
	logic [DATA_W-1:0] palRdData;

	// ====================================================================
	// Clocking
	// ====================================================================

	clockEnables uClockEnables (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.cen24P  (cen24P),
		.cen24N  (cen24N),
		.pixelEn (pixelEn)
	);

	// ====================================================================
	// CPU bus glue
	// ====================================================================

	cpuBusGlue uCpuBusGlue (
		.CLK_48M      (CLK_48M),
		.nRESET       (nRESET),
		.systemType   (systemType),
		.m68kAddr     (m68kAddr),
		.m68kData     (m68kData),
		.nPortWe      (nPortWe),
		.nBackupWeL   (nBackupWeL),
		.nBackupWeU   (nBackupWeU),
		.sramUnlock   (sramUnlock),
		.romSel       (romSel),
		.ramSel       (ramSel),
		.promReady    (promReady),
		.ramReady     (ramReady),
		.nDtackIn     (nDtackIn),
		.ipl0In       (ipl0In),
		.ipl1In       (ipl1In),
		.cdIrq        (cdIrq),
		.p2RomAddr    (p2RomAddr),
		.iplOut       (iplOut),
		.nDtackOut    (nDtackOut),
		.backupChange (backupChange)
	);

	// ====================================================================
	// Colour path
	// ====================================================================

	// Pixel index addresses the read port directly
	paletteRam uPaletteRam (
		.CLK_48M    (CLK_48M),
		.palWe      (palWe),
		.palBank    (palBank),
		.palWrIndex (palWrIndex),
		.palData    (palData),
		.rdIndex    (pixelIndex),
		.rdData     (palRdData)
	);

	colorDecode uColorDecode (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.pixelEn   (pixelEn),
		.shadow    (shadow),
		.colorWord (palRdData),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

// File: tb/neoSystemGlue_assert.sv
/*
 * Protocol assertions for the system glue top level
 * Pixel strobe spacing, exclusive 24 MHz phases, single-cycle backup flag
 */
module neoSystemGlueAssert (
	input logic CLK_48M,
	input logic nRESET,
	input logic pixelEn,
	input logic cen24P,
	input logic cen24N,
	input logic backupChange
);

	timeunit 1ns;
	timeprecision 100ps;

	// Number of failed assertions
	int failCount = 0;

	// One pixel strobe per 8 master cycles
	pixelSpacing: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		pixelEn |=> !pixelEn [*7])
		else begin
			$error("pixelEn high twice within 8 cycles");
			failCount++;
		end

	// 24 MHz phases are exclusive
	phaseExclusive: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		!(cen24P && cen24N))
		else begin
			$error("cen24P and cen24N high together");
			failCount++;
		end

	// Backup flag is a single-cycle pulse
	backupPulse: assert property (@(posedge CLK_48M) disable iff (!nRESET)
		backupChange |=> !backupChange)
		else begin
			$error("backupChange held longer than one cycle");
			failCount++;
		end

endmodule

bind neoSystemGlue neoSystemGlueAssert uAssert (.*);

// File: tb/neoSystemGlueTb.sv
/*
 * Directed testbench for the NeoGeo system glue
 * Covers clock enables, port banking, interrupts, DTACK stretching,
 * the backup flag and the palette to RGB path
 */
module neoSystemGlueTb import neoSysPkg::*, neoVideoPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic                   CLK_48M;
	logic                   nRESET;
	systemType_e            systemType;
	logic [M68K_ADDR_W:1]   m68kAddr;
	logic [DATA_W-1:0]      m68kData;
	logic                   nPortWe, nBackupWeL, nBackupWeU, sramUnlock;
	logic                   romSel, ramSel, promReady, ramReady, nDtackIn;
	logic                   ipl0In, ipl1In, cdIrq;
	logic                   palWe, palBank, shadow;
	logic [PAL_INDEX_W-1:0] palWrIndex, pixelIndex;
	logic [DATA_W-1:0]      palData;
	logic [CHANNEL_W-1:0]   red, green, blue;
	logic                   pixelEn, cen24P, cen24N, nDtackOut, backupChange;
	logic [PROM_ADDR_W-1:0] p2RomAddr;
	logic [IPL_W-1:0]       iplOut;

	int          errors;
	int          checks;
	logic [31:0] lfsrState;

	neoSystemGlue DUT (.*);

	// 100 MHz stand-in for the 48 MHz master clock
	initial begin
		CLK_48M = 1'b0;
		forever #5 CLK_48M = ~CLK_48M;
	end

	// Next rising edge plus the drive delay
	task automatic stepCycle();
		@(posedge CLK_48M);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH %0t ns %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int startErrors);
		$display("Test %s: %s, %0d errors", name,
			(errors == startErrors) ? "ok" : "FAILED", errors - startErrors);
	endtask

	// Cycles up to and including the next pixelEn, sampled at the falling edge
	task automatic waitPixelEn(output int cycles);
		cycles = 0;
		do begin
			@(negedge CLK_48M);
			cycles++;
		end while (!pixelEn && cycles < 32);
		if (!pixelEn) begin
			$display("TIMEOUT: pixelEn did not rise within 32 cycles");
			errors++;
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic randomBits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			lfsrState = lfsrNext(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
	endtask

	// Reference colour rule, 6-bit level minus dark, widened to 8 bits
	function automatic int expectChannel(input logic [3:0] nib, input logic extra,
		input logic dark, input logic sh);
		int lvl;
		int v;
		lvl = int'(nib) * 4 + int'(extra) * 2 + int'(nib[3]) - int'(dark);
		if (lvl < 0) begin
			v = 0;
		end else begin
			v = lvl * 4 + ((lvl >> 3) & 3);
		end
		return sh ? v / 2 : v;
	endfunction

	// ====================================================================
	// Tests
	// ====================================================================

	task automatic testClockEnables();
		int startErrors;
		int cycles;
		startErrors = errors;
		stepCycle();
		nRESET = 1'b0;
		repeat (3) @(posedge CLK_48M);
		#1;
		nRESET = 1'b1;
		waitPixelEn(cycles);
		checkValue("first pixelEn cycle", cycles, 8);
		repeat (3) begin
			waitPixelEn(cycles);
			checkValue("pixelEn period", cycles, 8);
		end
		// Phase 7 just ended, so the phase now counts up from 0
		for (int i = 0; i < 16; i++) begin
			@(negedge CLK_48M);
			checkValue("cen24P", cen24P, i[0]);
			checkValue("cen24N", cen24N, !i[0]);
		end
		reportTest("clock enables", startErrors);
	endtask

	// Multi-cycle strobe, bank loads after the rising edge
	task automatic portWrite(input logic [DATA_W-1:0] data);
		stepCycle();
		m68kData = data;
		nPortWe = 1'b0;
		repeat (2) stepCycle();
		nPortWe = 1'b1;
		repeat (2) stepCycle();
	endtask

	task automatic testPortBank();
		int startErrors;
		startErrors = errors;
		stepCycle();
		systemType = SYS_MVS;
		m68kAddr = {4'h0, 19'h2A5A5};
		portWrite(16'h0005);
		@(negedge CLK_48M);
		checkValue("p2RomAddr", p2RomAddr, (32'd5 << 20) | (32'h2A5A5 << 1));
		// CD ignores the write
		stepCycle();
		systemType = SYS_CD;
		m68kAddr = {4'h0, 19'h01234};
		portWrite(16'h0009);
		@(negedge CLK_48M);
		checkValue("p2RomAddr", p2RomAddr, (32'd5 << 20) | (32'h01234 << 1));
		reportTest("port bank", startErrors);
	endtask

	task automatic testInterrupts();
		int         startErrors;
		logic [2:0] c;
		logic [2:0] exp;
		startErrors = errors;
		for (int s = 0; s < 4; s++) begin
			for (int k = 0; k < 8; k++) begin
				c = k[2:0];
				stepCycle();
				systemType = systemType_e'(s);
				{cdIrq, ipl1In, ipl0In} = c;
				@(negedge CLK_48M);
				// CD boards swap the lines and add the CD interrupt on IPL2
				if (s >= 2) begin
					exp = {~c[2], c[2] | c[0], c[2] | c[1]};
				end else begin
					exp = {1'b1, c[1], c[0]};
				end
				checkValue("iplOut", iplOut, exp);
			end
		end
		stepCycle();
		{cdIrq, ipl1In, ipl0In} = 3'b011;
		reportTest("interrupts", startErrors);
	endtask

	task automatic testDtack();
		int   startErrors;
		logic exp;
		startErrors = errors;
		// sel 0 none, 1 ROM, 2 RAM
		for (int sel = 0; sel < 3; sel++) begin
			for (int rdy = 0; rdy < 2; rdy++) begin
				for (int dt = 0; dt < 2; dt++) begin
					stepCycle();
					romSel = (sel == 1);
					ramSel = (sel == 2);
					// Unselected ready input holds the opposite level
					promReady = (sel == 1) ? rdy[0] : !rdy[0];
					ramReady = (sel == 2) ? rdy[0] : !rdy[0];
					nDtackIn = dt[0];
					@(negedge CLK_48M);
					exp = (sel != 0 && !rdy[0]) ? 1'b1 : dt[0];
					checkValue("nDtackOut", nDtackOut, exp);
				end
			end
		end
		stepCycle();
		{romSel, ramSel} = 2'b00;
		nDtackIn = 1'b1;
		reportTest("dtack", startErrors);
	endtask

	task automatic backupCase(input systemType_e sys, input logic unlock,
		input logic [14:0] word, input logic upper, input int expPulses);
		int pulses;
		stepCycle();
		systemType = sys;
		sramUnlock = unlock;
		m68kAddr = {8'h00, word};
		stepCycle();
		nBackupWeL = upper;
		nBackupWeU = !upper;
		pulses = 0;
		// Three-cycle strobe, then a quiet tail
		for (int k = 0; k < 6; k++) begin
			stepCycle();
			if (k == 2) begin
				{nBackupWeL, nBackupWeU} = 2'b11;
			end
			@(negedge CLK_48M);
			if (backupChange) begin
				pulses++;
			end
		end
		checkValue("backupChange pulses", pulses, expPulses);
	endtask

	task automatic testBackup();
		int startErrors;
		startErrors = errors;
		backupCase(SYS_MVS, 1'b1, 15'h0190, 1'b0, 1);
		backupCase(SYS_MVS, 1'b1, 15'h418F, 1'b1, 1);
		backupCase(SYS_MVS, 1'b1, 15'h2000, 1'b0, 1);
		backupCase(SYS_MVS, 1'b1, 15'h4190, 1'b0, 0);
		backupCase(SYS_MVS, 1'b1, 15'h018F, 1'b1, 0);
		backupCase(SYS_MVS, 1'b0, 15'h0190, 1'b0, 0);
		backupCase(SYS_AES, 1'b1, 15'h0190, 1'b0, 0);
		reportTest("backup flag", startErrors);
	endtask

	task automatic testPalette();
		int                     startErrors;
		int                     cycles;
		logic [31:0]            v;
		logic [DATA_W-1:0]      words [12];
		logic [DATA_W-1:0]      w;
		logic [PAL_INDEX_W-1:0] idx;
		startErrors = errors;
		// Same six indices in each bank, so a bank mix-up shows
		for (int e = 0; e < 12; e++) begin
			randomBits(16, v);
			words[e] = (e == 3) ? 16'h8000 : v[15:0];
			idx = PAL_INDEX_W'((e % 6) * 397 + 5);
			stepCycle();
			palBank = (e >= 6);
			palWrIndex = idx;
			palData = words[e];
			palWe = 1'b1;
			stepCycle();
			palWe = 1'b0;
		end
		// Start on a pixel boundary
		waitPixelEn(cycles);
		stepCycle();
		for (int s = 0; s < 2; s++) begin
			for (int e = 0; e < 12; e++) begin
				palBank = (e >= 6);
				pixelIndex = PAL_INDEX_W'((e % 6) * 397 + 5);
				shadow = s[0];
				waitPixelEn(cycles);
				stepCycle();
				w = words[e];
				checkValue("red", red, expectChannel(w[11:8], w[14], w[15], shadow));
				checkValue("green", green, expectChannel(w[7:4], w[13], w[15], shadow));
				checkValue("blue", blue, expectChannel(w[3:0], w[12], w[15], shadow));
			end
		end
		reportTest("palette colour", startErrors);
	endtask

	// ====================================================================
	// Sequence
	// ====================================================================

	initial begin
		errors = 0;
		checks = 0;
		lfsrState = 32'd99565;
		nRESET = 1'b0;
		systemType = SYS_MVS;
		m68kAddr = '0;
		m68kData = '0;
		{nPortWe, nBackupWeL, nBackupWeU, promReady, ramReady, nDtackIn, ipl0In, ipl1In} = '1;
		{sramUnlock, romSel, ramSel, cdIrq, palWe, palBank, shadow} = '0;
		palWrIndex = '0;
		pixelIndex = '0;
		palData = '0;
		testClockEnables();
		testPortBank();
		testInterrupts();
		testDtack();
		testBackup();
		testPalette();
		// Protocol assertions bound into the DUT
		errors += DUT.uAssert.failCount;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// File: flist.f
design/neoSysPkg.sv
design/neoVideoPkg.sv
design/clockEnables.sv
design/cpuBusGlue.sv
design/paletteRam.sv
design/colorDecode.sv
design/neoSystemGlue.sv
tb/neoSystemGlue_assert.sv
tb/neoSystemGlueTb.sv

// File: Bender.yml
package:
  name: neo_system_glue

sources:
  - design/neoSysPkg.sv
  - design/neoVideoPkg.sv
  - design/clockEnables.sv
  - design/cpuBusGlue.sv
  - design/paletteRam.sv
  - design/colorDecode.sv
  - design/neoSystemGlue.sv
  - target: test
    files:
      - tb/neoSystemGlue_assert.sv
      - tb/neoSystemGlueTb.sv
